// ==== decoder.sv ====
`default_nettype none

`include "tartaruga_config.svh"

module decoder (
    input  logic [`TARTARUGA_XLEN-1:0] pc_i,
    input  logic [31:0]                instr_i,
    output tartaruga_pkg::decoded_t    decoded_o
);
    logic [6:0]                 opcode;
    logic [2:0]                 funct3;
    logic [6:0]                 funct7;
    logic [`TARTARUGA_XLEN-1:0] imm_i;
    logic [`TARTARUGA_XLEN-1:0] imm_u;
    logic [`TARTARUGA_XLEN-1:0] imm_b;
    tartaruga_pkg::alu_op_e     op;

    assign opcode = instr_i[6:0];
    assign funct3 = instr_i[14:12];
    assign funct7 = instr_i[31:25];

    assign imm_i = {{20{instr_i[31]}}, instr_i[31:20]};
    assign imm_u = {instr_i[31:12], 12'b0};
    assign imm_b = {{20{instr_i[31]}}, instr_i[7], instr_i[30:25], instr_i[11:8], 1'b0};

    always_comb begin
        op = tartaruga_pkg::OP_NOP;
        case (opcode)
            7'b0110011: begin
                case ({funct7, funct3})
                    10'b0000000_000: op = tartaruga_pkg::OP_ADD;
                    10'b0100000_000: op = tartaruga_pkg::OP_SUB;
                    10'b0000000_111: op = tartaruga_pkg::OP_AND;
                    10'b0000000_110: op = tartaruga_pkg::OP_OR;
                    10'b0000000_100: op = tartaruga_pkg::OP_XOR;
                    10'b0000000_010: op = tartaruga_pkg::OP_SLT;
                    default:         op = tartaruga_pkg::OP_NOP;
                endcase
            end
            7'b0010011: begin
                case (funct3)
                    3'b000:  op = tartaruga_pkg::OP_ADD;
                    3'b111:  op = tartaruga_pkg::OP_AND;
                    3'b110:  op = tartaruga_pkg::OP_OR;
                    3'b100:  op = tartaruga_pkg::OP_XOR;
                    default: op = tartaruga_pkg::OP_NOP;
                endcase
            end
            7'b0110111: op = tartaruga_pkg::OP_LUI;
            7'b1100011: begin
                case (funct3)
                    3'b000:  op = tartaruga_pkg::OP_BEQ;
                    3'b001:  op = tartaruga_pkg::OP_BNE;
                    default: op = tartaruga_pkg::OP_NOP;
                endcase
            end
            default: op = tartaruga_pkg::OP_NOP;
        endcase
    end

    always_comb begin
        decoded_o.pc      = pc_i;
        decoded_o.op      = op;
        decoded_o.rd      = instr_i[11:7];
        decoded_o.br_off  = imm_b;
        decoded_o.use_imm = (opcode == 7'b0010011) || (op == tartaruga_pkg::OP_LUI);
        decoded_o.imm     = (op == tartaruga_pkg::OP_LUI) ? imm_u : imm_i;
        // unused source fields read as x0 so they never cause a stall
        decoded_o.rs1 = (op == tartaruga_pkg::OP_NOP || op == tartaruga_pkg::OP_LUI) ?
                        '0 : instr_i[19:15];
        decoded_o.rs2 = (opcode == 7'b0110011 || opcode == 7'b1100011) && op != tartaruga_pkg::OP_NOP ?
                        instr_i[24:20] : '0;
        decoded_o.we  = op != tartaruga_pkg::OP_BEQ && op != tartaruga_pkg::OP_BNE &&
                        op != tartaruga_pkg::OP_NOP && instr_i[11:7] != 5'd0;
    end

endmodule

`default_nettype wire

// ==== exe.sv ====
`default_nettype none

`include "tartaruga_config.svh"

module exe (
    input logic        clk_i,
    input logic        rstn_i,
    issue_if.slave     issue,
    complete_if.master complete,
    input logic        flush_i
);
    logic [`TARTARUGA_XLEN-1:0] op_a;
    logic [`TARTARUGA_XLEN-1:0] op_b;
    logic [`TARTARUGA_XLEN-1:0] result;
    logic                       taken;

    assign op_a = issue.rs1_val;
    assign op_b = issue.decoded.use_imm ? issue.decoded.imm : issue.rs2_val;

    always_comb begin
        result = '0;
        taken  = 1'b0;
        case (issue.decoded.op)
            tartaruga_pkg::OP_ADD: result = op_a + op_b;
            tartaruga_pkg::OP_SUB: result = op_a - op_b;
            tartaruga_pkg::OP_AND: result = op_a & op_b;
            tartaruga_pkg::OP_OR:  result = op_a | op_b;
            tartaruga_pkg::OP_XOR: result = op_a ^ op_b;
            tartaruga_pkg::OP_SLT: result = {{(`TARTARUGA_XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
            tartaruga_pkg::OP_LUI: result = op_b;
            // branches compare the two registers and write nothing
            tartaruga_pkg::OP_BEQ: taken = issue.rs1_val == issue.rs2_val;
            tartaruga_pkg::OP_BNE: taken = issue.rs1_val != issue.rs2_val;
            default:               result = '0;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (!rstn_i || flush_i) begin
            complete.valid <= 1'b0;
        end else begin
            complete.valid <= issue.valid;
        end
    end

    always_ff @(posedge clk_i) begin
        complete.rob_idx      <= issue.rob_idx;
        complete.result       <= result;
        complete.branch_taken <= taken;
        complete.target       <= issue.decoded.pc + issue.decoded.br_off;
    end

endmodule

`default_nettype wire

// ==== fetch.sv ====
`default_nettype none

`include "tartaruga_config.svh"

module fetch (
    input  logic                                      clk_i,
    input  logic                                      rstn_i,
    input  logic                                      run_i,
    input  logic                                      stall_i,
    input  logic                                      redirect_i,
    input  logic [`TARTARUGA_XLEN-1:0]                redirect_pc_i,
    input  logic                                      imem_we_i,
    input  logic [$clog2(`TARTARUGA_IMEM_DEPTH)-1:0]  imem_addr_i,
    input  logic [31:0]                               imem_data_i,
    output logic [`TARTARUGA_XLEN-1:0]                pc_o,
    output logic [31:0]                               instr_o,
    output logic                                      valid_o
);
    localparam int AW = $clog2(`TARTARUGA_IMEM_DEPTH);

    logic [31:0]                imem [`TARTARUGA_IMEM_DEPTH];
    logic [`TARTARUGA_XLEN-1:0] pc_q;

    // program load port
    always_ff @(posedge clk_i) begin
        if (imem_we_i) begin
            imem[imem_addr_i] <= imem_data_i;
        end
    end

    // redirect wins over both stall and run
    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            pc_q <= '0;
        end else if (redirect_i) begin
            pc_q <= redirect_pc_i;
        end else if (run_i && !stall_i) begin
            pc_q <= pc_q + 'd4;
        end
    end

    assign pc_o    = pc_q;
    // word index, wraps past the end of memory
    assign instr_o = imem[pc_q[AW+1:2]];
    assign valid_o = run_i;

endmodule

`default_nettype wire

// ==== regfile.sv ====
`default_nettype none

`include "tartaruga_config.svh"

module regfile (
    input  logic                       clk_i,
    input  logic                       rstn_i,
    input  tartaruga_pkg::reg_addr_t   rs1_i,
    input  tartaruga_pkg::reg_addr_t   rs2_i,
    input  tartaruga_pkg::reg_addr_t   rd_i,
    input  logic                       we_i,
    input  logic [`TARTARUGA_XLEN-1:0] wdata_i,
    output logic [`TARTARUGA_XLEN-1:0] rdata1_o,
    output logic [`TARTARUGA_XLEN-1:0] rdata2_o
);
    logic [`TARTARUGA_XLEN-1:0] regs [32];

    // architectural state starts at zero
    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i && rd_i != '0) begin
            regs[rd_i] <= wdata_i;
        end
    end

    assign rdata1_o = (rs1_i == '0) ? '0 : regs[rs1_i];
    assign rdata2_o = (rs2_i == '0) ? '0 : regs[rs2_i];

endmodule

`default_nettype wire

// ==== rob.sv ====
`default_nettype none

`include "tartaruga_config.svh"

module rob (
    input  logic                       clk_i,
    input  logic                       rstn_i,
    input  logic                       alloc_valid_i,
    input  tartaruga_pkg::decoded_t    alloc_decoded_i,
    output tartaruga_pkg::rob_idx_t    alloc_idx_o,
    output logic                       full_o,
    complete_if.slave                  complete,
    input  tartaruga_pkg::reg_addr_t   rs1_i,
    input  tartaruga_pkg::reg_addr_t   rs2_i,
    output logic                       hit1_o,
    output logic                       done1_o,
    output tartaruga_pkg::rob_idx_t    idx1_o,
    output logic [`TARTARUGA_XLEN-1:0] val1_o,
    output logic                       hit2_o,
    output logic                       done2_o,
    output tartaruga_pkg::rob_idx_t    idx2_o,
    output logic [`TARTARUGA_XLEN-1:0] val2_o,
    output logic                       flush_o,
    output logic [`TARTARUGA_XLEN-1:0] flush_pc_o,
    output logic                       commit_valid_o,
    output logic [`TARTARUGA_XLEN-1:0] commit_pc_o,
    output tartaruga_pkg::reg_addr_t   commit_rd_o,
    output logic                       commit_we_o,
    output logic [`TARTARUGA_XLEN-1:0] commit_result_o
);
    localparam int DEPTH = `TARTARUGA_ROB_DEPTH;
    localparam int CW    = $clog2(DEPTH) + 1;

    logic [`TARTARUGA_XLEN-1:0] pc_q     [DEPTH];
    tartaruga_pkg::reg_addr_t   rd_q     [DEPTH];
    logic                       we_q     [DEPTH];
    logic [`TARTARUGA_XLEN-1:0] result_q [DEPTH];
    logic                       taken_q  [DEPTH];
    logic [`TARTARUGA_XLEN-1:0] target_q [DEPTH];
    logic [DEPTH-1:0]           done_q;
    tartaruga_pkg::rob_idx_t    head_q;
    tartaruga_pkg::rob_idx_t    tail_q;
    logic [CW-1:0]              count_q;
    logic                       commit;

    // walk oldest to youngest so the last match is the newest writer
    function automatic void lookup(
        input  tartaruga_pkg::reg_addr_t   rs,
        output logic                       hit,
        output logic                       done,
        output tartaruga_pkg::rob_idx_t    idx,
        output logic [`TARTARUGA_XLEN-1:0] val
    );
        tartaruga_pkg::rob_idx_t slot;
        hit  = 1'b0;
        done = 1'b0;
        idx  = '0;
        val  = '0;
        for (int i = 0; i < DEPTH; i++) begin
            slot = head_q + tartaruga_pkg::rob_idx_t'(i);
            if (CW'(i) < count_q && we_q[slot] && rd_q[slot] == rs) begin
                hit  = 1'b1;
                done = done_q[slot];
                idx  = slot;
                val  = result_q[slot];
            end
        end
    endfunction

    always_comb begin
        lookup(rs1_i, hit1_o, done1_o, idx1_o, val1_o);
        lookup(rs2_i, hit2_o, done2_o, idx2_o, val2_o);
    end

    assign alloc_idx_o = tail_q;
    assign full_o      = count_q == CW'(DEPTH);

    // head leaves once its result is in
    assign commit          = (count_q != '0) && done_q[head_q];
    assign commit_valid_o  = commit;
    assign commit_pc_o     = pc_q[head_q];
    assign commit_rd_o     = rd_q[head_q];
    assign commit_we_o     = commit && we_q[head_q];
    assign commit_result_o = result_q[head_q];
    assign flush_o         = commit && taken_q[head_q];
    assign flush_pc_o      = target_q[head_q];

    always_ff @(posedge clk_i) begin
        if (!rstn_i || flush_o) begin
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= '0;
            done_q  <= '0;
        end else begin
            if (alloc_valid_i) begin
                done_q[tail_q] <= 1'b0;
                tail_q         <= tail_q + 1'b1;
            end
            if (complete.valid) begin
                done_q[complete.rob_idx] <= 1'b1;
            end
            if (commit) begin
                head_q <= head_q + 1'b1;
            end
            count_q <= count_q + CW'(alloc_valid_i) - CW'(commit);
        end
    end

    always_ff @(posedge clk_i) begin
        if (alloc_valid_i) begin
            pc_q[tail_q] <= alloc_decoded_i.pc;
            rd_q[tail_q] <= alloc_decoded_i.rd;
            we_q[tail_q] <= alloc_decoded_i.we;
        end
        if (complete.valid) begin
            result_q[complete.rob_idx] <= complete.result;
            taken_q[complete.rob_idx]  <= complete.branch_taken;
            target_q[complete.rob_idx] <= complete.target;
        end
    end

endmodule

`default_nettype wire

// ==== sim.f ====
+incdir+.
tartaruga_pkg.sv
tartaruga_if.sv
fetch.sv
decoder.sv
regfile.sv
rob.sv
exe.sv
tartaruga_top.sv
tb_tartaruga.sv

// ==== tartaruga_config.svh ====
`ifndef TARTARUGA_CONFIG_SVH
`define TARTARUGA_CONFIG_SVH

// data and address width
`define TARTARUGA_XLEN 32

// must stay a power of two
`define TARTARUGA_ROB_DEPTH 4

// instruction words
`define TARTARUGA_IMEM_DEPTH 64

`endif

// ==== tartaruga_if.sv ====
`default_nettype none

`include "tartaruga_config.svh"

// one instruction leaving decode for exe
interface issue_if;
    logic                       valid;
    tartaruga_pkg::decoded_t    decoded;
    tartaruga_pkg::rob_idx_t    rob_idx;
    logic [`TARTARUGA_XLEN-1:0] rs1_val;
    logic [`TARTARUGA_XLEN-1:0] rs2_val;

    modport master (output valid, decoded, rob_idx, rs1_val, rs2_val);
    modport slave (input valid, decoded, rob_idx, rs1_val, rs2_val);
endinterface

// result written back into the reorder buffer
interface complete_if;
    logic                       valid;
    tartaruga_pkg::rob_idx_t    rob_idx;
    logic [`TARTARUGA_XLEN-1:0] result;
    logic                       branch_taken;
    logic [`TARTARUGA_XLEN-1:0] target;

    modport master (output valid, rob_idx, result, branch_taken, target);
    modport slave (input valid, rob_idx, result, branch_taken, target);
endinterface

`default_nettype wire

// ==== tartaruga_pkg.sv ====
`default_nettype none

`include "tartaruga_config.svh"

package tartaruga_pkg;

    typedef enum logic [3:0] {
        OP_ADD,
        OP_SUB,
        OP_AND,
        OP_OR,
        OP_XOR,
        OP_SLT,
        OP_LUI,
        OP_BEQ,
        OP_BNE,
        OP_NOP
    } alu_op_e;

    typedef logic [4:0] reg_addr_t;

    typedef logic [$clog2(`TARTARUGA_ROB_DEPTH)-1:0] rob_idx_t;

    typedef struct packed {
        logic [`TARTARUGA_XLEN-1:0] pc;
        alu_op_e                    op;
        reg_addr_t                  rs1;
        reg_addr_t                  rs2;
        reg_addr_t                  rd;
        logic                       we;
        logic                       use_imm;
        logic [`TARTARUGA_XLEN-1:0] imm;
        logic [`TARTARUGA_XLEN-1:0] br_off;
    } decoded_t;

endpackage

`default_nettype wire

// ==== tartaruga_top.sv ====
`default_nettype none

`include "tartaruga_config.svh"

module tartaruga_top (
    input  logic                                     clk_i,
    input  logic                                     rstn_i,
    input  logic                                     imem_we_i,
    input  logic [$clog2(`TARTARUGA_IMEM_DEPTH)-1:0] imem_addr_i,
    input  logic [31:0]                              imem_data_i,
    input  logic                                     run_i,
    output logic                                     commit_valid_o,
    output logic [`TARTARUGA_XLEN-1:0]               commit_pc_o,
    output tartaruga_pkg::reg_addr_t                 commit_rd_o,
    output logic                                     commit_we_o,
    output logic [`TARTARUGA_XLEN-1:0]               commit_result_o
);
    logic [`TARTARUGA_XLEN-1:0] fetch_pc;
    logic [31:0]                fetch_instr;
    logic                       fetch_valid;
    logic [`TARTARUGA_XLEN-1:0] dec_pc_q;
    logic [31:0]                dec_instr_q;
    logic                       dec_valid_q;
    tartaruga_pkg::decoded_t    dec;
    logic [`TARTARUGA_XLEN-1:0] rf1, rf2;
    logic                       hit1, done1, hit2, done2;
    tartaruga_pkg::rob_idx_t    idx1, idx2, alloc_idx;
    logic [`TARTARUGA_XLEN-1:0] val1, val2, op1, op2;
    logic                       ok1, ok2;
    logic                       rob_full, flush, stall, issue_valid;
    logic [`TARTARUGA_XLEN-1:0] flush_pc;

    issue_if    issue ();
    complete_if complete ();

    fetch u_fetch (
        .clk_i(clk_i), .rstn_i(rstn_i), .run_i(run_i), .stall_i(stall),
        .redirect_i(flush), .redirect_pc_i(flush_pc),
        .imem_we_i(imem_we_i), .imem_addr_i(imem_addr_i), .imem_data_i(imem_data_i),
        .pc_o(fetch_pc), .instr_o(fetch_instr), .valid_o(fetch_valid)
    );

    // decode register, held on stall and emptied by a flush
    always_ff @(posedge clk_i) begin
        if (!rstn_i || flush) begin
            dec_valid_q <= 1'b0;
        end else if (!stall) begin
            dec_valid_q <= fetch_valid;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!stall) begin
            dec_pc_q    <= fetch_pc;
            dec_instr_q <= fetch_instr;
        end
    end

    decoder u_decoder (.pc_i(dec_pc_q), .instr_i(dec_instr_q), .decoded_o(dec));

    regfile u_regfile (
        .clk_i(clk_i), .rstn_i(rstn_i), .rs1_i(dec.rs1), .rs2_i(dec.rs2),
        .rd_i(commit_rd_o), .we_i(commit_we_o), .wdata_i(commit_result_o),
        .rdata1_o(rf1), .rdata2_o(rf2)
    );

    // completed rob entry first, then the exe output, then the register file
    function automatic logic [`TARTARUGA_XLEN-1:0] operand(
        input  logic                       hit,
        input  logic                       done,
        input  tartaruga_pkg::rob_idx_t    idx,
        input  logic [`TARTARUGA_XLEN-1:0] rob_val,
        input  logic [`TARTARUGA_XLEN-1:0] rf_val,
        output logic                       ok
    );
        ok = 1'b1;
        if (!hit) begin
            return rf_val;
        end
        if (done) begin
            return rob_val;
        end
        if (complete.valid && complete.rob_idx == idx) begin
            return complete.result;
        end
        ok = 1'b0;
        return rf_val;
    endfunction

    always_comb begin
        op1 = operand(hit1, done1, idx1, val1, rf1, ok1);
        op2 = operand(hit2, done2, idx2, val2, rf2, ok2);
    end

    assign stall       = dec_valid_q & (rob_full | ~ok1 | ~ok2);
    assign issue_valid = dec_valid_q & ~stall;

    // issue slot, a bubble goes in when nothing issues
    always_ff @(posedge clk_i) begin
        if (!rstn_i || flush) begin
            issue.valid <= 1'b0;
        end else begin
            issue.valid <= issue_valid;
        end
    end

    always_ff @(posedge clk_i) begin
        issue.decoded <= dec;
        issue.rob_idx <= alloc_idx;
        issue.rs1_val <= op1;
        issue.rs2_val <= op2;
    end

    exe u_exe (
        .clk_i(clk_i), .rstn_i(rstn_i), .issue(issue.slave),
        .complete(complete.master), .flush_i(flush)
    );

    rob u_rob (
        .clk_i(clk_i), .rstn_i(rstn_i),
        .alloc_valid_i(issue_valid), .alloc_decoded_i(dec), .alloc_idx_o(alloc_idx),
        .full_o(rob_full), .complete(complete.slave),
        .rs1_i(dec.rs1), .rs2_i(dec.rs2),
        .hit1_o(hit1), .done1_o(done1), .idx1_o(idx1), .val1_o(val1),
        .hit2_o(hit2), .done2_o(done2), .idx2_o(idx2), .val2_o(val2),
        .flush_o(flush), .flush_pc_o(flush_pc),
        .commit_valid_o(commit_valid_o), .commit_pc_o(commit_pc_o),
        .commit_rd_o(commit_rd_o), .commit_we_o(commit_we_o),
        .commit_result_o(commit_result_o)
    );

endmodule

`default_nettype wire

// ==== tb_tartaruga.sv ====
`default_nettype none

`include "tartaruga_config.svh"

module tb_tartaruga;
    localparam int DEPTH = `TARTARUGA_IMEM_DEPTH;
    localparam int AW    = $clog2(DEPTH);

    logic                       clk_i;
    logic                       rstn_i;
    logic                       imem_we_i;
    logic [AW-1:0]              imem_addr_i;
    logic [31:0]                imem_data_i;
    logic                       run_i;
    logic                       commit_valid_o;
    logic [`TARTARUGA_XLEN-1:0] commit_pc_o;
    logic [4:0]                 commit_rd_o;
    logic                       commit_we_o;
    logic [`TARTARUGA_XLEN-1:0] commit_result_o;

    logic [31:0] prog [DEPTH];
    int          prog_len;
    logic [31:0] exp_pc [$];
    logic [4:0]  exp_rd [$];
    logic        exp_we [$];
    logic [31:0] exp_res [$];
    logic [31:0] loop_pc;
    logic        expect_idle;
    int          error_count = 0;
    int          check_count = 0;
    int          commit_count = 0;
    int          cycle_count = 0;
    int          cycle_limit = 0;
    integer      seed = 32'h1a5f_65e0;

    tartaruga_top u_dut (
        .clk_i(clk_i), .rstn_i(rstn_i), .imem_we_i(imem_we_i), .imem_addr_i(imem_addr_i),
        .imem_data_i(imem_data_i), .run_i(run_i), .commit_valid_o(commit_valid_o),
        .commit_pc_o(commit_pc_o), .commit_rd_o(commit_rd_o), .commit_we_o(commit_we_o),
        .commit_result_o(commit_result_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #5 clk_i = ~clk_i;
    end

    function automatic logic [31:0] rtype(input int f7, input int f3, input int rd,
                                          input int rs1, input int rs2);
        return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'b0110011};
    endfunction

    function automatic logic [31:0] itype(input int f3, input int rd, input int rs1, input int imm);
        return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], 7'b0010011};
    endfunction

    function automatic logic [31:0] utype(input int rd, input int imm);
        return {imm[19:0], rd[4:0], 7'b0110111};
    endfunction

    function automatic logic [31:0] btype(input int f3, input int rs1, input int rs2, input int off);
        return {off[12], off[10:5], rs2[4:0], rs1[4:0], f3[2:0], off[4:1], off[11], 7'b1100011};
    endfunction

    task automatic emit(input logic [31:0] word);
        prog[prog_len] = word;
        prog_len++;
    endtask

    task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
        check_count++;
        assert (act === exp) else begin
            error_count++;
            $display("error at %0t: %s expected %h, got %h", $time, name, exp, act);
        end
    endtask

    // dependent chains, x0 writes and both branch kinds
    task automatic build_fixed();
        prog_len = 0;
        emit(itype(0, 1, 0, 5));         // addi x1, x0, 5
        emit(itype(0, 2, 1, -3));        // addi x2, x1, -3
        emit(rtype(0, 0, 3, 2, 1));      // add  x3, x2, x1
        emit(rtype(32, 0, 4, 3, 2));     // sub  x4, x3, x2
        emit(rtype(0, 4, 5, 4, 3));      // xor  x5, x4, x3
        emit(rtype(0, 6, 6, 5, 1));      // or   x6, x5, x1
        emit(rtype(0, 7, 7, 6, 3));      // and  x7, x6, x3
        emit(rtype(0, 2, 8, 2, 7));      // slt  x8, x2, x7
        emit(utype(9, 20'habcde));       // lui  x9, 0xabcde
        emit(itype(6, 9, 9, 12'h123));   // ori  x9, x9, 0x123
        emit(itype(4, 10, 9, -1));       // xori x10, x9, -1
        emit(itype(7, 11, 10, 12'h0f0)); // andi x11, x10, 0xf0
        emit(itype(0, 0, 1, 9));         // addi x0, x1, 9
        emit(rtype(0, 0, 12, 0, 1));     // add  x12, x0, x1
        emit(btype(0, 1, 12, 8));        // beq  x1, x12, +8 taken
        emit(itype(0, 13, 0, 99));
        emit(btype(1, 1, 12, 8));        // bne  x1, x12, +8 not taken
        emit(rtype(0, 0, 0, 4, 5));      // add  x0, x4, x5
        emit(btype(1, 0, 4, 12));        // bne  x0, x4, +12 taken
        emit(itype(0, 14, 0, 1));
        emit(itype(0, 15, 0, 2));
        emit(btype(0, 2, 8, 8));         // beq  x2, x8, +8 not taken
        emit(rtype(0, 2, 16, 0, 12));    // slt  x16, x0, x12
        emit(btype(0, 0, 0, 0));
    endtask

    // random subset program, branches only jump forward inside it
    task automatic make_random(input int n);
        int kind, rd, rs1, rs2, imm, lim;
        prog_len = 0;
        for (int i = 0; i < n; i++) begin
            kind = $unsigned($random(seed)) % 13;
            rd   = $unsigned($random(seed)) % 16;
            rs1  = $unsigned($random(seed)) % 16;
            rs2  = $unsigned($random(seed)) % 16;
            imm  = $random(seed);
            lim  = (n - i < 4) ? n - i : 4;
            case (kind)
                0:  emit(rtype(0, 0, rd, rs1, rs2));
                1:  emit(rtype(32, 0, rd, rs1, rs2));
                2:  emit(rtype(0, 7, rd, rs1, rs2));
                3:  emit(rtype(0, 6, rd, rs1, rs2));
                4:  emit(rtype(0, 4, rd, rs1, rs2));
                5:  emit(rtype(0, 2, rd, rs1, rs2));
                6:  emit(itype(0, rd, rs1, imm));
                7:  emit(itype(7, rd, rs1, imm));
                8:  emit(itype(6, rd, rs1, imm));
                9:  emit(itype(4, rd, rs1, imm));
                10: emit(utype(rd, imm));
                default: emit(btype(kind - 11, rs1, rs2, 4 * (1 + $unsigned(imm) % lim)));
            endcase
        end
        emit(btype(0, 0, 0, 0));
    endtask

    // sequential ISA model, fills the expected commit stream
    task automatic predict();
        logic [31:0] regs [32];
        logic [31:0] ins, a, b, imm, boff, res, pc;
        logic        we, taken;
        exp_pc.delete();
        exp_rd.delete();
        exp_we.delete();
        exp_res.delete();
        foreach (regs[i]) regs[i] = '0;
        pc = '0;
        for (int steps = 0; steps < 1000; steps++) begin
            ins   = prog[pc[AW+1:2]];
            a     = regs[ins[19:15]];
            b     = regs[ins[24:20]];
            imm   = {{20{ins[31]}}, ins[31:20]};
            boff  = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
            res   = '0;
            taken = 1'b0;
            we    = (ins[6:0] == 7'b0110011) || (ins[6:0] == 7'b0010011) ||
                    (ins[6:0] == 7'b0110111);
            case (ins[6:0])
                7'b0110011: case ({ins[31:25], ins[14:12]})
                    10'b0000000_000: res = a + b;
                    10'b0100000_000: res = a - b;
                    10'b0000000_111: res = a & b;
                    10'b0000000_110: res = a | b;
                    10'b0000000_100: res = a ^ b;
                    10'b0000000_010: res = {31'b0, $signed(a) < $signed(b)};
                    default:         we = 1'b0;
                endcase
                7'b0010011: case (ins[14:12])
                    3'b000:  res = a + imm;
                    3'b111:  res = a & imm;
                    3'b110:  res = a | imm;
                    3'b100:  res = a ^ imm;
                    default: we = 1'b0;
                endcase
                7'b0110111: res = {ins[31:12], 12'b0};
                7'b1100011: taken = (ins[14:12] == 3'b000 && a == b) ||
                                    (ins[14:12] == 3'b001 && a != b);
                default: ;
            endcase
            we = we && ins[11:7] != 5'd0;
            if (we) regs[ins[11:7]] = res;
            exp_pc.push_back(pc);
            exp_rd.push_back(ins[11:7]);
            exp_we.push_back(we);
            exp_res.push_back(res);
            // a taken branch onto itself ends the program
            if (taken && boff == '0) begin
                loop_pc = pc;
                break;
            end
            pc = taken ? pc + boff : pc + 32'd4;
        end
    endtask

    // reset, load, run to the final loop, optionally pausing run_i once
    task automatic execute_program(input int pause_after);
        int base;
        predict();
        cycle_limit += 90 + 20 * exp_pc.size() + ((pause_after > 0) ? 60 : 0);
        expect_idle = 1'b1;
        rstn_i      = 1'b0;
        run_i       = 1'b0;
        repeat (3) @(negedge clk_i);
        rstn_i = 1'b1;
        for (int a = 0; a < DEPTH; a++) begin
            imem_we_i   = 1'b1;
            imem_addr_i = a[AW-1:0];
            // unused words decode as nops tagged with their address
            imem_data_i = (a < prog_len) ? prog[a] : {a[24:0], 7'b0000000};
            @(negedge clk_i);
        end
        imem_we_i   = 1'b0;
        expect_idle = 1'b0;
        run_i       = 1'b1;
        base        = commit_count;
        if (pause_after > 0) begin
            while (commit_count < base + pause_after) @(negedge clk_i);
            run_i = 1'b0;
            repeat (20) @(negedge clk_i);
            expect_idle = 1'b1;
            repeat (20) @(negedge clk_i);
            expect_idle = 1'b0;
            run_i       = 1'b1;
        end
        while (exp_pc.size() != 0) @(negedge clk_i);
        run_i = 1'b0;
        repeat (15) @(negedge clk_i);
    endtask

    always @(posedge clk_i) begin : commit_check
        logic [31:0] pc_e;
        logic [4:0]  rd_e;
        logic        we_e;
        logic [31:0] res_e;
        if (rstn_i && expect_idle) begin
            assert (!commit_valid_o) else begin
                error_count++;
                $display("error at %0t: commit_valid_o expected 0, got 1", $time);
            end
        end else if (rstn_i && commit_valid_o) begin
            commit_count++;
            if (exp_pc.size() == 0) begin
                // past the end only the self-loop may commit again
                check_value("commit_pc_o", loop_pc, commit_pc_o);
                check_value("commit_we_o", 32'd0, {31'b0, commit_we_o});
            end else begin
                pc_e  = exp_pc.pop_front();
                rd_e  = exp_rd.pop_front();
                we_e  = exp_we.pop_front();
                res_e = exp_res.pop_front();
                check_value("commit_pc_o", pc_e, commit_pc_o);
                check_value("commit_we_o", {31'b0, we_e}, {31'b0, commit_we_o});
                check_value("commit_rd_o", {27'b0, rd_e}, {27'b0, commit_rd_o});
                check_value("commit_result_o", res_e, commit_result_o);
            end
        end
    end

    always @(posedge clk_i) begin
        cycle_count++;
        if (cycle_count > cycle_limit) begin
            $display("timeout after %0d cycles, expected commits still missing", cycle_count);
            $display("commits %0d, checks %0d, errors %0d", commit_count, check_count, error_count);
            $display("Result: FAILED");
            $finish;
        end
    end

    initial begin
        rstn_i      = 1'b0;
        run_i       = 1'b0;
        imem_we_i   = 1'b0;
        imem_addr_i = '0;
        imem_data_i = '0;
        expect_idle = 1'b1;
        build_fixed();
        execute_program(0);
        // same program again with run_i dropped after six commits
        execute_program(6);
        for (int p = 0; p < 4; p++) begin
            make_random(50);
            execute_program(0);
        end
        $display("commits %0d, checks %0d, errors %0d", commit_count, check_count, error_count);
        if (error_count == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
